//--- run.sh
#!/usr/bin/env bash
# Build and run the camera config testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
        --top-module tb_camera_cfg -o sim_camera_cfg \
        && ./obj_dir/sim_camera_cfg 2>&1 | tee sim.log

grep -qx "TEST PASS" sim.log && echo "Simulation passed" \
        || { echo "Simulation failed"; exit 1; }

//--- src.f
+incdir+src
src/sccb_pkg.sv
src/sccb_bit_timer.sv
src/sccb_master.sv
src/cfg_sequencer.sv
src/camera_cfg_top.sv
tb/sccb_checker.sv
tb/sccb_slave_model.sv
tb/tb_camera_cfg.sv

//--- src/camera_cfg_top.sv
// Camera sensor register init engine
// Sequencer, quarter-bit timer and SCCB master

`timescale 1ns/10ps

module camera_cfg_top #(
        parameter int CLK_DIV       = 125,      // 100 kHz bus from 50 MHz
        parameter int SETTLE_CYCLES = 10000
) (
        input  logic                    sclk,
        input  logic                    s_rst_n,
        output logic                    scl,
        inout  wire                     sda,
        input  logic                    estart,
        input  sccb_pkg::cfg_word_u     ewdata,
        output sccb_pkg::reg_val_t      riic_data,
        output logic                    cfg_done
);

logic                   cmd_start;
sccb_pkg::cfg_word_u    cmd_word;
logic                   busy;
logic                   run;
logic                   tick;
logic [1:0]             phase;

cfg_sequencer #(
        .SETTLE_CYCLES  (SETTLE_CYCLES)
) i_sequencer (
        .sclk           (sclk),
        .s_rst_n        (s_rst_n),
        .estart         (estart),
        .ewdata         (ewdata),
        .busy           (busy),
        .cmd_start      (cmd_start),
        .cmd_word       (cmd_word),
        .cfg_done       (cfg_done)
);

sccb_bit_timer #(
        .CLK_DIV        (CLK_DIV)
) i_bit_timer (
        .sclk           (sclk),
        .s_rst_n        (s_rst_n),
        .run            (run),
        .tick           (tick),
        .phase          (phase)
);

sccb_master i_master (
        .sclk           (sclk),
        .s_rst_n        (s_rst_n),
        .cmd_start      (cmd_start),
        .cmd_word       (cmd_word),
        .tick           (tick),
        .phase          (phase),
        .run            (run),
        .busy           (busy),
        .scl            (scl),
        .sda            (sda),
        .riic_data      (riic_data)
);

endmodule

//--- src/cfg_sequencer.sv
// Init table sequencer
// Steps the register table one entry per bus transaction,
// waits the settling time, then hands the bus to the debug port

`timescale 1ns/10ps

`include "cfg_table.svh"

module cfg_sequencer #(
        parameter int SETTLE_CYCLES = 10000
) (
        input  logic                    sclk,
        input  logic                    s_rst_n,
        input  logic                    estart,
        input  sccb_pkg::cfg_word_u     ewdata,
        input  logic                    busy,
        output logic                    cmd_start,
        output sccb_pkg::cfg_word_u     cmd_word,
        output logic                    cfg_done
);

localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

logic [sccb_pkg::CFG_IDX_W-1:0]         cfg_index;
logic                                   start;
logic [2:0]                             busy_arr;
logic                                   busy_neg;
logic                                   tbl_end;
logic                                   counting;
logic [CNT_W-1:0]                       cnt_settle;
sccb_pkg::cfg_word_u                    tbl_word;

//****************************************
// Table walk
//****************************************
assign tbl_end  = (cfg_index == sccb_pkg::CFG_IDX_W'(sccb_pkg::CFG_NUM));
assign busy_neg = busy_arr[2] & ~busy_arr[1];
assign tbl_word = tbl_end ? '0 : CFG_TABLE[cfg_index];

always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n)
                busy_arr <= 3'b000;
        else
                busy_arr <= {busy_arr[1:0], busy};
end

always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n)
                start <= 1'b0;
        else if (cfg_index == '0 && !start)     // Kick off entry 0
                start <= 1'b1;
        else if (busy_neg && !tbl_end)
                start <= 1'b1;
        else
                start <= 1'b0;
end

always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n)
                cfg_index <= '0;
        else if (start)
                cfg_index <= cfg_index + 1'b1;
end

//****************************************
// Settling time after the last write
//****************************************
assign counting = !cfg_done && (cnt_settle != '0 || (tbl_end && busy_neg));

always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n)
                cnt_settle <= '0;
        else if (counting)
                cnt_settle <= cnt_settle + 1'b1;
end

always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n)
                cfg_done <= 1'b0;
        else if (counting && cnt_settle == CNT_W'(SETTLE_CYCLES - 1))
                cfg_done <= 1'b1;               // Held until reset
end

// Debug port owns the bus once init is over
assign cmd_start = cfg_done ? (estart & ~busy) : start;
assign cmd_word  = cfg_done ? ewdata : tbl_word;

endmodule

//--- src/cfg_table.svh
// Sensor register init table
// Soft reset, PLL setup, output size and stream enable

`ifndef CFG_TABLE_SVH
`define CFG_TABLE_SVH

localparam sccb_pkg::cfg_word_u CFG_TABLE [sccb_pkg::CFG_NUM] = '{
        //      ID                   REG_ADDR  REG_VAL
        {sccb_pkg::SCCB_WR_ID, 16'h3008, 8'h82},        // Soft reset
        {sccb_pkg::SCCB_WR_ID, 16'h3008, 8'h42},        // Power down during setup
        {sccb_pkg::SCCB_WR_ID, 16'h3103, 8'h03},        // System clock from PLL
        {sccb_pkg::SCCB_WR_ID, 16'h3034, 8'h1a},
        {sccb_pkg::SCCB_WR_ID, 16'h3035, 8'h21},        // PLL system divider
        {sccb_pkg::SCCB_WR_ID, 16'h3036, 8'h69},        // PLL multiplier
        {sccb_pkg::SCCB_WR_ID, 16'h3037, 8'h13},        // PLL root and pre divider
        {sccb_pkg::SCCB_WR_ID, 16'h3808, 8'h04},        // Output width 1024
        {sccb_pkg::SCCB_WR_ID, 16'h3809, 8'h00},
        {sccb_pkg::SCCB_WR_ID, 16'h380a, 8'h02},        // Output height 720
        {sccb_pkg::SCCB_WR_ID, 16'h380b, 8'hd0},
        {sccb_pkg::SCCB_WR_ID, 16'h3008, 8'h02}         // Wake up, start streaming
};

`endif

//--- src/sccb_bit_timer.sv
// Quarter-bit timer for the SCCB master
// Divides sclk into phase ticks while a transaction runs

`timescale 1ns/10ps

module sccb_bit_timer #(
        parameter int CLK_DIV = 125
) (
        input  logic            sclk,
        input  logic            s_rst_n,
        input  logic            run,
        output logic            tick,
        output logic [1:0]      phase
);

localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

logic [CW-1:0]  div_cnt;

assign tick = run && (div_cnt == CW'(CLK_DIV - 1));

// Restarts on every idle gap, so the first tick lands CLK_DIV after start
always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n)
                div_cnt <= '0;
        else if (!run || tick)
                div_cnt <= '0;
        else
                div_cnt <= div_cnt + 1'b1;
end

// 0: data change, 1: scl rise, 2: sample, 3: scl fall
always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n)
                phase <= 2'd0;
        else if (!run)
                phase <= 2'd0;
        else if (tick)
                phase <= phase + 2'd1;
end

endmodule

//--- src/sccb_master.sv
// SCCB byte engine
// One write (id + 3 bytes) or one read (id + addr, repeated
// start, read id, data byte, NACK) per command word

`timescale 1ns/10ps

module sccb_master (
        input  logic                    sclk,
        input  logic                    s_rst_n,
        input  logic                    cmd_start,
        input  sccb_pkg::cfg_word_u     cmd_word,
        input  logic                    tick,
        input  logic [1:0]              phase,
        output logic                    run,
        output logic                    busy,
        output logic                    scl,
        inout  wire                     sda,
        output sccb_pkg::reg_val_t      riic_data
);

localparam logic [2:0] ST_IDLE   = 3'd0;
localparam logic [2:0] ST_START  = 3'd1;
localparam logic [2:0] ST_BYTE   = 3'd2;
localparam logic [2:0] ST_ACK    = 3'd3;
localparam logic [2:0] ST_RSTART = 3'd4;
localparam logic [2:0] ST_RBYTE  = 3'd5;
localparam logic [2:0] ST_STOP   = 3'd6;

logic [2:0]                     state;
logic [2:0]                     bit_cnt;
logic [2:0]                     byte_cnt;       // 4 marks the read data byte
logic                           sda_oe;         // 1 pulls the line low
sccb_pkg::cfg_word_u            cmd_q;
sccb_pkg::reg_val_t             cur_byte;
sccb_pkg::reg_val_t             rx_sh;

assign busy = (state != ST_IDLE);
assign run  = busy;
assign sda  = sda_oe ? 1'b0 : 1'bz;

// Byte on the wire, picked from the bus view
always_comb begin
        case (byte_cnt)
                3'd0:    cur_byte = {cmd_q.bus.dev_addr, 1'b0};
                3'd1:    cur_byte = cmd_q.bus.tx_bytes[2];
                3'd2:    cur_byte = cmd_q.bus.tx_bytes[1];
                default: cur_byte = cmd_q.bus.rd ? {cmd_q.bus.dev_addr, 1'b1}
                                                 : cmd_q.bus.tx_bytes[0];
        endcase
end

always_ff @(posedge sclk) begin
        if (state == ST_IDLE && cmd_start)
                cmd_q <= cmd_word;
        if (tick && state == ST_RBYTE && phase == 2'd2)
                rx_sh <= {rx_sh[6:0], sda};             // MSB first
end

//****************************************
// Transaction FSM
//****************************************
always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
                state     <= ST_IDLE;
                bit_cnt   <= 3'd7;
                byte_cnt  <= 3'd0;
                scl       <= 1'b1;
                sda_oe    <= 1'b0;
                riic_data <= '0;
        end else if (state == ST_IDLE) begin
                if (cmd_start) begin
                        state    <= ST_START;
                        bit_cnt  <= 3'd7;
                        byte_cnt <= 3'd0;
                end
        end else if (tick) begin
                if (phase == 2'd1)
                        scl <= 1'b1;
                if (phase == 2'd3 && state != ST_STOP)
                        scl <= 1'b0;

                case (state)
                ST_START, ST_RSTART: begin
                        if (phase == 2'd0)
                                sda_oe <= 1'b0;
                        if (phase == 2'd2)
                                sda_oe <= 1'b1;         // Falling sda under high scl
                        if (phase == 2'd3) begin
                                state   <= ST_BYTE;
                                bit_cnt <= 3'd7;
                        end
                end
                ST_BYTE, ST_RBYTE: begin
                        if (phase == 2'd0)
                                sda_oe <= (state == ST_BYTE) & ~cur_byte[bit_cnt];
                        if (phase == 2'd3) begin
                                if (bit_cnt == 3'd0)
                                        state <= ST_ACK;
                                bit_cnt <= bit_cnt - 3'd1;
                        end
                end
                ST_ACK: begin
                        if (phase == 2'd0)
                                sda_oe <= 1'b0;         // ACK ignored, NACK after data
                        if (phase == 2'd3) begin
                                bit_cnt <= 3'd7;
                                if (byte_cnt == 3'd4 || (byte_cnt == 3'd3 && !cmd_q.bus.rd)) begin
                                        state <= ST_STOP;
                                end else if (cmd_q.bus.rd && byte_cnt == 3'd2) begin
                                        state    <= ST_RSTART;
                                        byte_cnt <= 3'd3;
                                end else if (cmd_q.bus.rd && byte_cnt == 3'd3) begin
                                        state    <= ST_RBYTE;
                                        byte_cnt <= 3'd4;
                                end else begin
                                        state    <= ST_BYTE;
                                        byte_cnt <= byte_cnt + 3'd1;
                                end
                        end
                end
                ST_STOP: begin
                        if (phase == 2'd0)
                                sda_oe <= 1'b1;
                        if (phase == 2'd2)
                                sda_oe <= 1'b0;         // Rising sda under high scl
                        if (phase == 2'd3) begin
                                state <= ST_IDLE;
                                if (cmd_q.bus.rd)
                                        riic_data <= rx_sh;
                        end
                end
                default: state <= ST_IDLE;
                endcase
        end
end

endmodule

//--- src/sccb_pkg.sv
// Shared SCCB definitions
// Command word union with register and bus views,
// register byte type, table size and device id

package sccb_pkg;

        typedef logic [7:0] reg_val_t;          // Register value / read data

        // Register view, as written in the init table
        typedef struct packed {
                logic [7:0]     dev_id;
                logic [15:0]    reg_addr;
                reg_val_t       reg_val;
        } cfg_reg_t;

        // Bus view, as shifted out by the master
        typedef struct packed {
                logic [6:0]             dev_addr;
                logic                   rd;             // Low bit of device id
                logic [2:0][7:0]        tx_bytes;       // [2] goes out first
        } cfg_bus_t;

        typedef union packed {
                cfg_reg_t       regs;
                cfg_bus_t       bus;
        } cfg_word_u;

        //****************************************
        // Table and bus constants
        //****************************************
        localparam int CFG_NUM          = 12;
        localparam int CFG_IDX_W        = 4;

        localparam logic [7:0] SCCB_WR_ID = 8'h78;      // Read id is 8'h79

endpackage

//--- tb/sccb_checker.sv
// SCCB bus protocol assertions
// Bound to the master: line stability, idle clock and command pacing

`timescale 1ns/10ps

module sccb_checker (
        input  logic    sclk,
        input  logic    s_rst_n,
        input  logic    cmd_start,
        input  logic    busy,
        input  logic    scl,
        input  logic    sda,
        input  logic    edge_state      // Start, repeated start or stop
);

// sda moves under a high scl only for start and stop
a_sda_stable: assert property (@(posedge sclk) disable iff (!s_rst_n)
        (scl && $past(scl) && $changed(sda)) |-> edge_state)
        else $error("sda changed while scl was high outside a start or stop");

a_idle_scl: assert property (@(posedge sclk) disable iff (!s_rst_n)
        !busy |-> scl)
        else $error("scl low while the master is idle");

a_busy_cause: assert property (@(posedge sclk) disable iff (!s_rst_n)
        $rose(busy) |-> $past(cmd_start))
        else $error("busy rose without a command start pulse");

a_start_idle: assert property (@(posedge sclk) disable iff (!s_rst_n)
        cmd_start |-> !busy)
        else $error("command start pulse issued while busy");

endmodule

//--- tb/sccb_slave_model.sv
// Behavioral SCCB camera sensor
// Register memory, write log, transaction count and read answers

`timescale 1ns/10ps

module sccb_slave_model (
        input  logic    scl,
        inout  wire     sda
);

sccb_pkg::reg_val_t     mem [0:65535];
sccb_pkg::cfg_word_u    wr_log [0:63];
int                     wr_cnt = 0;
int                     xact_cnt = 0;           // One per stop condition

logic           scl_q = 1'b1;
logic           sda_q = 1'b1;
logic           drv_low = 1'b0;
logic           in_frame = 1'b0;
logic           sending = 1'b0;
logic [3:0]     bit_cnt = 4'd0;
logic [2:0]     byte_idx = 3'd0;
logic [7:0]     sh = 8'h00;
logic [7:0]     tx = 8'h00;
logic [7:0]     dev_id = 8'h00;
logic [15:0]    addr = 16'h0000;
logic [7:0]     val = 8'h00;

assign sda = drv_low ? 1'b0 : 1'bz;

initial begin
        for (int a = 0; a < 65536; a++)
                mem[a] = a[15:8] ^ a[7:0] ^ 8'h5a;
end

always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
                in_frame = 1'b1;                // Start or repeated start
                sending  = 1'b0;
                bit_cnt  = 4'd0;
                byte_idx = 3'd0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
                if (in_frame) begin
                        xact_cnt++;
                        if (!dev_id[0] && byte_idx == 3'd4) begin
                                mem[addr]      = val;
                                wr_log[wr_cnt] = {dev_id, addr, val};
                                wr_cnt++;
                        end
                end
                in_frame = 1'b0;
                drv_low  = 1'b0;
        end else if (in_frame && scl_q === 1'b0 && scl === 1'b1) begin
                if (bit_cnt < 4'd8)
                        sh = {sh[6:0], sda};
                bit_cnt++;
        end else if (in_frame && scl_q === 1'b1 && scl === 1'b0) begin
                if (bit_cnt == 4'd8) begin
                        if (sending) begin
                                sending = 1'b0;         // Master sends the NACK
                                drv_low = 1'b0;
                        end else begin
                                case (byte_idx)
                                3'd0:    dev_id = sh;
                                3'd1:    addr[15:8] = sh;
                                3'd2:    addr[7:0] = sh;
                                default: val = sh;
                                endcase
                                drv_low = 1'b1;         // ACK
                        end
                        byte_idx++;
                end else if (bit_cnt == 4'd9) begin
                        drv_low = 1'b0;
                        bit_cnt = 4'd0;
                        if (dev_id[0] && byte_idx == 3'd1) begin
                                sending = 1'b1;
                                tx      = mem[addr];
                                drv_low = ~tx[7];
                        end
                end else if (sending) begin
                        drv_low = ~tx[3'(7 - bit_cnt)];
                end
        end
        scl_q = scl;
        sda_q = sda;
end

endmodule

//--- tb/tb_camera_cfg.sv
// Testbench for the camera register init engine
// Clock, reset, debug step table, compare tasks, timeout and verdict

`timescale 1ns/10ps

`include "cfg_table.svh"

module tb_camera_cfg;

localparam int CLK_DIV        = 4;
localparam int SETTLE_CYCLES  = 64;
localparam int NUM_STEPS      = 6;
localparam int XACT_TICKS     = 200;            // A read takes 192 quarter bits
localparam int TIMEOUT_CYCLES =
        2 * ((sccb_pkg::CFG_NUM + NUM_STEPS) * XACT_TICKS * CLK_DIV + SETTLE_CYCLES);

typedef struct packed {
        sccb_pkg::cfg_word_u    word;
        logic                   rd;
        logic                   dbl;            // Second estart while busy
        sccb_pkg::reg_val_t     exp_val;
} step_t;

logic                   sclk;
logic                   s_rst_n;
logic                   estart;
sccb_pkg::cfg_word_u    ewdata;
sccb_pkg::reg_val_t     riic_data;
logic                   cfg_done;
wire                    scl;
wire                    sda;

step_t                  steps [NUM_STEPS];
int                     cyc = 0;
int                     chk_cnt = 0;
int                     err_cnt = 0;

pullup (sda);

camera_cfg_top #(
        .CLK_DIV        (CLK_DIV),
        .SETTLE_CYCLES  (SETTLE_CYCLES)
) i_dut (
        .sclk           (sclk),
        .s_rst_n        (s_rst_n),
        .scl            (scl),
        .sda            (sda),
        .estart         (estart),
        .ewdata         (ewdata),
        .riic_data      (riic_data),
        .cfg_done       (cfg_done)
);

sccb_slave_model i_slave (
        .scl            (scl),
        .sda            (sda)
);

bind sccb_master sccb_checker i_checker (
        .sclk           (sclk),
        .s_rst_n        (s_rst_n),
        .cmd_start      (cmd_start),
        .busy           (busy),
        .scl            (scl),
        .sda            (sda),
        .edge_state     (state == ST_START || state == ST_RSTART || state == ST_STOP)
);

initial sclk = 1'b0;
always #20 sclk = ~sclk;

always @(posedge sclk) cyc <= cyc + 1;

//****************************************
// Compare tasks
//****************************************
task automatic check_word(input string name, input sccb_pkg::cfg_word_u exp,
                          input sccb_pkg::cfg_word_u act);
        chk_cnt++;
        if (act !== exp) begin
                err_cnt++;
                $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
endtask

task automatic check_byte(input string name, input sccb_pkg::reg_val_t exp,
                          input sccb_pkg::reg_val_t act);
        chk_cnt++;
        if (act !== exp) begin
                err_cnt++;
                $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
endtask

task automatic check_level(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
                err_cnt++;
                $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
endtask

task automatic check_count(input string name, input int exp, input int act);
        chk_cnt++;
        if (act != exp) begin
                err_cnt++;
                $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
endtask

function automatic sccb_pkg::cfg_word_u make_word(input logic rd, input logic [15:0] addr,
                                                  input sccb_pkg::reg_val_t val);
        sccb_pkg::cfg_word_u w;
        w.regs.dev_id   = sccb_pkg::SCCB_WR_ID | {7'd0, rd};
        w.regs.reg_addr = addr;
        w.regs.reg_val  = val;
        return w;
endfunction

//****************************************
// Stimulus and checks
//****************************************
initial begin
        sccb_pkg::reg_val_t     rnd [4];
        sccb_pkg::reg_val_t     blk_snap [2];
        sccb_pkg::reg_val_t     shadow;
        int                     seen;
        int                     last_stop_cyc;
        int                     done_cyc;
        logic                   pulsed_init;
        logic                   pulsed_settle;
        string                  name;

        s_rst_n = 1'b0;
        estart  = 1'b0;
        ewdata  = '0;
        void'($urandom(59800));
        for (int i = 0; i < 4; i++)
                rnd[i] = 8'($urandom());
        repeat (2) @(negedge sclk);
        s_rst_n = 1'b1;

        i_slave.mem[16'h6123] = rnd[2];         // Preloaded for a read step
        blk_snap[0] = i_slave.mem[16'h4000];
        blk_snap[1] = i_slave.mem[16'h4001];
        check_level("cfg_done after reset", 1'b0, cfg_done);
        check_byte("riic_data after reset", 8'h00, riic_data);

        steps[0] = '{make_word(1'b0, 16'h5000, rnd[0]), 1'b0, 1'b0, rnd[0]};
        steps[1] = '{make_word(1'b0, 16'h5001, rnd[1]), 1'b0, 1'b1, rnd[1]};
        steps[2] = '{make_word(1'b1, 16'h5000, 8'h00), 1'b1, 1'b0, rnd[0]};
        steps[3] = '{make_word(1'b1, 16'h6123, 8'h00), 1'b1, 1'b0, rnd[2]};
        steps[4] = '{make_word(1'b1, 16'h5001, 8'h00), 1'b1, 1'b1, rnd[1]};
        steps[5] = '{make_word(1'b1, CFG_TABLE[5].regs.reg_addr, 8'h00), 1'b1, 1'b0,
                     CFG_TABLE[5].regs.reg_val};

        // Init phase, with debug pulses that must be ignored
        seen          = 0;
        last_stop_cyc = 0;
        pulsed_init   = 1'b0;
        pulsed_settle = 1'b0;
        while (!cfg_done) begin
                @(negedge sclk);
                estart = 1'b0;
                if (i_slave.xact_cnt != seen) begin
                        seen          = i_slave.xact_cnt;
                        last_stop_cyc = cyc;
                end
                if (!pulsed_init && seen == 3 && !i_dut.busy) begin
                        ewdata      = make_word(1'b0, 16'h4000, 8'hee);
                        estart      = 1'b1;
                        pulsed_init = 1'b1;
                end
                if (!pulsed_settle && seen == sccb_pkg::CFG_NUM && !i_dut.busy) begin
                        ewdata        = make_word(1'b0, 16'h4001, 8'hee);
                        estart        = 1'b1;
                        pulsed_settle = 1'b1;
                end
        end
        estart   = 1'b0;
        done_cyc = cyc;

        check_count("init writes logged", sccb_pkg::CFG_NUM, i_slave.wr_cnt);
        check_count("bus transactions before done", sccb_pkg::CFG_NUM, i_slave.xact_cnt);
        for (int i = 0; i < sccb_pkg::CFG_NUM; i++) begin
                name = $sformatf("init write %0d", i);
                check_byte({name, " id"}, sccb_pkg::SCCB_WR_ID, i_slave.wr_log[i].regs.dev_id);
                check_word(name, CFG_TABLE[i], i_slave.wr_log[i]);
        end
        check_level("settle time before done", 1'b1, (done_cyc - last_stop_cyc) >= SETTLE_CYCLES);
        check_byte("estart during init", blk_snap[0], i_slave.mem[16'h4000]);
        check_byte("estart during settle", blk_snap[1], i_slave.mem[16'h4001]);

        // Debug port steps
        for (int i = 0; i < NUM_STEPS; i++) begin
                name   = $sformatf("debug step %0d", i);
                seen   = i_slave.xact_cnt;
                shadow = i_slave.mem[16'h5002];
                @(negedge sclk);
                ewdata = steps[i].word;
                estart = 1'b1;
                @(negedge sclk);
                estart = 1'b0;
                if (steps[i].dbl) begin
                        repeat (CLK_DIV * 8) @(negedge sclk);
                        ewdata = make_word(1'b0, 16'h5002, rnd[3]);
                        estart = 1'b1;
                        @(negedge sclk);
                        estart = 1'b0;
                end
                while (i_slave.xact_cnt == seen)
                        @(negedge sclk);
                while (i_dut.busy)
                        @(negedge sclk);
                repeat (4) @(negedge sclk);

                check_count({name, " transactions"}, seen + 1, i_slave.xact_cnt);
                check_level({name, " busy"}, 1'b0, i_dut.busy);
                if (steps[i].rd) begin
                        check_byte({name, " read data"}, steps[i].exp_val, riic_data);
                end else begin
                        check_byte({name, " written reg"}, steps[i].exp_val,
                                   i_slave.mem[steps[i].word.regs.reg_addr]);
                        check_word({name, " logged write"}, steps[i].word,
                                   i_slave.wr_log[i_slave.wr_cnt - 1]);
                end
                if (steps[i].dbl)
                        check_byte({name, " second estart"}, shadow, i_slave.mem[16'h5002]);
        end

        repeat (10) @(negedge sclk);
        check_level("cfg_done held", 1'b1, cfg_done);
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
                $display("TEST PASS");
        else
                $display("TEST FAIL");
        $finish;
end

initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        err_cnt++;
        $display("ERROR: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        $display("TEST FAIL");
        $finish;
end

endmodule
